// ==== design/rv_isa_pkg.sv ====
// RV32I instruction encoding used by the front-end stages
// Opcode values, format classes and the multi-format view of one instruction word
package rv_isa_pkg;

    // ======================================================================
    // Major opcodes and format classes
    // ======================================================================

    // Bits [6:0] of every 32-bit instruction
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_e;

    // Encoding format of a decoded word
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_ILLEGAL
    } instr_fmt_e;

    // ======================================================================
    // Per-format field layouts, MSB first
    // ======================================================================

    // Register-register ALU ops
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // Immediate ALU ops, loads, JALR
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Stores, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    // Conditional branches, bit 0 of offset implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    // Upper immediate
    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    // JAL offset, scrambled bit order
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // Same 32 bits, read through whichever format applies
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        b_type_t b_type;
        u_type_t u_type;
        j_type_t j_type;
    } rv_instr_u;

endpackage

// ==== design/frontend_pkg.sv ====
// Records carried between fetch, decode and the consumer of the front end
// Fetch and decode ports use these by scoped name
package frontend_pkg;

    // ======================================================================
    // Fetch to decode
    // ======================================================================

    // Fetched word with the address it came from
    typedef struct packed {
        logic [31:0]           pc;
        rv_isa_pkg::rv_instr_u ir;
    } pipe_if_id_t;

    // ======================================================================
    // Decode to consumer
    // ======================================================================

    // Unused register fields read as zero for the format
    // imm already sign-extended, zero for R and illegal
    typedef struct packed {
        logic [31:0]            pc;
        rv_isa_pkg::instr_fmt_e fmt;
        logic [6:0]             opcode;
        logic [2:0]             funct3;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [31:0]            imm;
    } decoded_t;

endpackage

// ==== design/instr_fetch.sv ====
// Instruction fetch stage with one request in flight and one-block lookahead
// Talks req/gnt to the instruction memory and valid/ready to decode
module instr_fetch #(
    parameter logic [31:0] pc_start = 32'h0
) (
    input  logic                      clk,
    input  logic                      rstz,
    // Instruction memory port
    output logic [31:0]               instr_addr,
    output logic                      instr_req,
    input  logic [31:0]               instr_data,
    input  logic                      instr_gnt,
    // Pipe to decode
    output frontend_pkg::pipe_if_id_t fetch,
    output logic                      pipe_out_vld,
    input  logic                      pipe_out_rdy,
    // Redirect from decode
    input  logic                      branch,
    input  logic [31:0]               branch_target
);

    typedef enum logic [1:0] {
        INIT,
        FETCH,
        STALL
    } fetch_state_e;

    fetch_state_e state;
    fetch_state_e next_state;

    // pc is the next address, pc_last the one awaiting its grant
    logic [31:0] pc;
    logic [31:0] pc_last;
    logic [31:0] redir_pc;
    logic [31:0] tgt;
    logic        redir_pend;
    logic        kill_q;
    logic        redirect;
    logic        update_pc;
    logic        fetch_vld;
    logic        fetch_rdy;
    logic        take;

    // ======================================================================
    // Request state machine
    // ======================================================================

    // Room in the pipe register, now or after this cycle's transfer
    assign fetch_rdy = ~fetch_vld | pipe_out_rdy;

    // Grant that lands in free space
    // Grant for the request issued in the redirect cycle is ignored
    assign take = (state != INIT) & instr_gnt & ~kill_q & fetch_rdy;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT:         next_state = FETCH;
            FETCH, STALL: next_state = take ? FETCH : STALL;
            default:      next_state = INIT;
        endcase
    end

    // ======================================================================
    // Program counter
    // ======================================================================

    assign update_pc = (next_state == FETCH);

    // Target straight from decode, or one parked while waiting on a grant
    assign redirect = branch | redir_pend;
    assign tgt      = branch ? branch_target : redir_pc;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pc      <= pc_start;
            pc_last <= '0;
        end else if (update_pc) begin
            if (redirect) begin
                // Target becomes the pending address, re-requested next cycle
                pc_last <= tgt;
                pc      <= tgt + 32'd4;
            end else begin
                pc_last <= pc;
                pc      <= pc + 32'd4;
            end
        end
    end

    // Park a jump that arrives with no grant to advance on
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            redir_pend <= 1'b0;
            kill_q     <= 1'b0;
        end else begin
            kill_q <= update_pc & redirect;
            if (update_pc) begin
                redir_pend <= 1'b0;
            end else if (branch) begin
                redir_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (branch && !update_pc) begin
            redir_pc <= branch_target;
        end
    end

    // ======================================================================
    // Pipe register to decode
    // ======================================================================

    // Jump flushes held word and any same-cycle grant
    // Grants while a redirect is parked are old-path words
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            fetch_vld <= 1'b0;
        end else if (branch) begin
            fetch_vld <= 1'b0;
        end else if (take && !redir_pend) begin
            fetch_vld <= 1'b1;
        end else if (pipe_out_rdy) begin
            fetch_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && !redir_pend && !branch) begin
            fetch.pc <= pc_last;
            fetch.ir <= instr_data;
        end
    end

    assign pipe_out_vld = fetch_vld;

    // Move on to pc only once the pending word is taken
    assign instr_addr = update_pc ? pc : pc_last;
    assign instr_req  = fetch_rdy;

endmodule

// ==== design/instr_rom.sv ====
// Synchronous instruction memory, loaded through a write port during reset
// Read data and grant come one cycle after the request, grant held back by stall
module instr_rom #(
    parameter int rom_words = 64
) (
    input  logic        clk,
    input  logic        rstz,
    // Fetch port
    input  logic [31:0] instr_addr,
    input  logic        instr_req,
    output logic [31:0] instr_data,
    output logic        instr_gnt,
    // Wait-state injection
    input  logic        stall,
    // Program load
    input  logic        prog_we,
    input  logic [31:0] prog_addr,
    input  logic [31:0] prog_data
);

    localparam int idx_w = (rom_words > 1) ? $clog2(rom_words) : 1;

    logic [31:0]      mem [rom_words];
    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    logic             gnt_q;

    // Byte address to word index, wrapping at the array depth
    assign rd_idx = idx_w'(instr_addr[31:2] % rom_words);
    assign wr_idx = idx_w'(prog_addr[31:2] % rom_words);

    // ======================================================================
    // Storage
    // ======================================================================

    // Loader only active while the core is held in reset
    always_ff @(posedge clk) begin
        if (!rstz && prog_we) begin
            mem[wr_idx] <= prog_data;
        end
    end

    // Read on every request, granted or not
    always_ff @(posedge clk) begin
        if (instr_req) begin
            instr_data <= mem[rd_idx];
        end
    end

    // ======================================================================
    // Grant
    // ======================================================================

    // One grant per request, dropped when stalled
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            gnt_q <= 1'b0;
        end else begin
            gnt_q <= instr_req & ~stall;
        end
    end

    assign instr_gnt = gnt_q;

endmodule

// ==== design/instr_decode.sv ====
// Instruction decode stage, splits each fetched word into fields and immediate
// Resolves JAL locally and redirects fetch; decoded records go out registered
module instr_decode (
    input  logic                      clk,
    input  logic                      rstz,
    // Pipe from fetch
    input  frontend_pkg::pipe_if_id_t fetch,
    input  logic                      pipe_out_vld,
    output logic                      pipe_out_rdy,
    // Redirect to fetch
    output logic                      branch,
    output logic [31:0]               branch_target,
    // Decoded output
    output frontend_pkg::decoded_t    dec,
    output logic                      dec_vld,
    input  logic                      dec_rdy
);

    import rv_isa_pkg::*;
    import frontend_pkg::*;

    rv_instr_u   ir;
    instr_fmt_e  fmt;
    decoded_t    dec_next;
    logic [31:0] imm;
    logic        has_rs1;
    logic        has_rs2;
    logic        has_rd;
    logic        accept;

    assign ir = fetch.ir;

    // ======================================================================
    // Format and immediate
    // ======================================================================

    always_comb begin
        case (ir.r_type.opcode)
            LUI, AUIPC:         fmt = FMT_U;
            JAL:                fmt = FMT_J;
            JALR, LOAD, OP_IMM: fmt = FMT_I;
            BRANCH:             fmt = FMT_B;
            STORE:              fmt = FMT_S;
            OP:                 fmt = FMT_R;
            default:            fmt = FMT_ILLEGAL;
        endcase
    end

    // Sign bit is always instruction bit 31
    always_comb begin
        case (fmt)
            FMT_I: imm = {{20{ir.i_type.imm_11_0[11]}}, ir.i_type.imm_11_0};
            FMT_S: imm = {{20{ir.s_type.imm_11_5[6]}}, ir.s_type.imm_11_5,
                          ir.s_type.imm_4_0};
            FMT_B: imm = {{19{ir.b_type.imm_12}}, ir.b_type.imm_12, ir.b_type.imm_11,
                          ir.b_type.imm_10_5, ir.b_type.imm_4_1, 1'b0};
            FMT_U: imm = {ir.u_type.imm_31_12, 12'h000};
            FMT_J: imm = {{11{ir.j_type.imm_20}}, ir.j_type.imm_20, ir.j_type.imm_19_12,
                          ir.j_type.imm_11, ir.j_type.imm_10_1, 1'b0};
            // R type and illegal carry no immediate
            default: imm = '0;
        endcase
    end

    // ======================================================================
    // Register fields
    // ======================================================================

    // funct3 present exactly where rs1 is
    assign has_rs1 = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
    assign has_rs2 = fmt inside {FMT_R, FMT_S, FMT_B};
    assign has_rd  = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};

    always_comb begin
        dec_next.pc     = fetch.pc;
        dec_next.fmt    = fmt;
        dec_next.opcode = ir.r_type.opcode;
        dec_next.funct3 = has_rs1 ? ir.r_type.funct3 : 3'b000;
        dec_next.rd     = has_rd ? ir.r_type.rd : 5'd0;
        dec_next.rs1    = has_rs1 ? ir.r_type.rs1 : 5'd0;
        dec_next.rs2    = has_rs2 ? ir.r_type.rs2 : 5'd0;
        dec_next.imm    = imm;
    end

    // ======================================================================
    // Handshakes and jump redirect
    // ======================================================================

    // Take a word when the output register is empty or draining
    assign pipe_out_rdy = ~dec_vld | dec_rdy;
    assign accept       = pipe_out_vld & pipe_out_rdy;

    // JAL target known here, the JAL record still goes out
    assign branch        = accept & (fmt == FMT_J);
    assign branch_target = fetch.pc + imm;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            dec_vld <= 1'b0;
        end else if (accept) begin
            dec_vld <= 1'b1;
        end else if (dec_rdy) begin
            dec_vld <= 1'b0;
        end
    end

    // Held steady while the consumer back-pressures
    always_ff @(posedge clk) begin
        if (accept) begin
            dec <= dec_next;
        end
    end

endmodule

// ==== design/rv_frontend.sv ====
// Top of the RV32I front end: fetch, instruction memory and decode
// Program is written through the load port while rstz is low
module rv_frontend #(
    parameter logic [31:0] pc_start  = 32'h0,
    parameter int          rom_words = 64
) (
    input  logic                   clk,
    input  logic                   rstz,
    // Memory wait states
    input  logic                   stall,
    // Program load
    input  logic                   prog_we,
    input  logic [31:0]            prog_addr,
    input  logic [31:0]            prog_data,
    // Decoded stream
    output frontend_pkg::decoded_t dec,
    output logic                   dec_vld,
    input  logic                   dec_rdy
);

    import frontend_pkg::*;

    // Memory port
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic        instr_req;
    logic        instr_gnt;

    // Fetch to decode
    pipe_if_id_t fetch;
    logic        pipe_out_vld;
    logic        pipe_out_rdy;

    // Jump redirect
    logic        branch;
    logic [31:0] branch_target;

    instr_fetch #(
        .pc_start (pc_start)
    ) u_instr_fetch (
        .clk           (clk),
        .rstz          (rstz),
        .instr_addr    (instr_addr),
        .instr_req     (instr_req),
        .instr_data    (instr_data),
        .instr_gnt     (instr_gnt),
        .fetch         (fetch),
        .pipe_out_vld  (pipe_out_vld),
        .pipe_out_rdy  (pipe_out_rdy),
        .branch        (branch),
        .branch_target (branch_target)
    );

    instr_rom #(
        .rom_words (rom_words)
    ) u_instr_rom (
        .clk        (clk),
        .rstz       (rstz),
        .instr_addr (instr_addr),
        .instr_req  (instr_req),
        .instr_data (instr_data),
        .instr_gnt  (instr_gnt),
        .stall      (stall),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data)
    );

    instr_decode u_instr_decode (
        .clk           (clk),
        .rstz          (rstz),
        .fetch         (fetch),
        .pipe_out_vld  (pipe_out_vld),
        .pipe_out_rdy  (pipe_out_rdy),
        .branch        (branch),
        .branch_target (branch_target),
        .dec           (dec),
        .dec_vld       (dec_vld),
        .dec_rdy       (dec_rdy)
    );

endmodule

// ==== verif/rv_frontend_tb.sv ====
// Testbench for the RV32I front end with program and expected trace from the cases file
// Runs the stream clean, with memory stalls, with back-pressure, and with both
module rv_frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import frontend_pkg::*;

    localparam int rom_words  = 64;
    localparam int case_words = 1024;
    localparam int hdr_words  = 2;
    localparam int rec_fields = 8;

    logic        clk;
    logic        rstz;
    logic        stall;
    logic        prog_we;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic        dec_rdy;
    decoded_t    dec;
    logic        dec_vld;

    // Header, program words, then 8 words per expected record
    logic [31:0] cases_mem [case_words];
    logic [31:0] lfsr;
    int          prog_len;
    int          rec_count;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          aborted;

    always #20 clk = ~clk;

    rv_frontend u_rv_frontend (
        .clk       (clk),
        .rstz      (rstz),
        .stall     (stall),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dec       (dec),
        .dec_vld   (dec_vld),
        .dec_rdy   (dec_rdy)
    );

    // ======================================================================
    // Random bits
    // ======================================================================

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = galois_step(lfsr);
    endtask

    // ======================================================================
    // Checking
    // ======================================================================

    task automatic compare_word(input int rec, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: record %0d dec.%s expected %h got %h",
                     $time, rec, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_record(input int rec);
        int base;
        base = hdr_words + prog_len + rec * rec_fields;
        compare_word(rec, "pc", cases_mem[base], dec.pc);
        compare_word(rec, "fmt", cases_mem[base + 1], 32'(dec.fmt));
        compare_word(rec, "opcode", cases_mem[base + 2], 32'(dec.opcode));
        compare_word(rec, "funct3", cases_mem[base + 3], 32'(dec.funct3));
        compare_word(rec, "rd", cases_mem[base + 4], 32'(dec.rd));
        compare_word(rec, "rs1", cases_mem[base + 5], 32'(dec.rs1));
        compare_word(rec, "rs2", cases_mem[base + 6], 32'(dec.rs2));
        compare_word(rec, "imm", cases_mem[base + 7], dec.imm);
    endtask

    // ======================================================================
    // Reset, program load and one pass over the trace
    // ======================================================================

    // Called on a falling edge and returns on the falling edge of release
    task automatic reset_and_load();
        int i;
        rstz    = 1'b0;
        stall   = 1'b0;
        dec_rdy = 1'b1;
        for (i = 0; i < prog_len; i++) begin
            prog_we   = 1'b1;
            prog_addr = 32'(i * 4);
            prog_data = cases_mem[hdr_words + i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        // Reset held 3 cycles past the last program write
        repeat (3) @(negedge clk);
        rstz = 1'b1;
    endtask

    task automatic run_stream(input string name, input bit use_stall, input bit use_bp);
        int       idx;
        int       cycles;
        int       limit;
        int       errs_before;
        logic     s_bit;
        logic     r_low;
        logic     hold;
        decoded_t held;
        errs_before = errors;
        idx         = 0;
        cycles      = 0;
        hold        = 1'b0;
        held        = '0;
        limit       = 20 * rec_count + 100;
        reset_and_load();
        // Output register still holds its reset value
        if (dec_vld !== 1'b0) begin
            $display("Error at %0d ns: dec_vld is not low after reset", $time);
            errors++;
        end
        @(negedge clk);
        while (idx < rec_count && cycles < limit) begin
            // Record refused last cycle must still be there unchanged
            if (hold) begin
                if (dec_vld !== 1'b1) begin
                    $display("Error at %0d ns: dec_vld dropped while the consumer held off",
                             $time);
                    errors++;
                end
                if (dec !== held) begin
                    $display("Mismatch at %0d ns: dec expected %h got %h", $time, held, dec);
                    errors++;
                end
            end
            s_bit = 1'b0;
            r_low = 1'b0;
            if (use_stall) begin
                draw_bit(s_bit);
            end
            if (use_bp) begin
                draw_bit(r_low);
            end
            stall   = s_bit;
            dec_rdy = ~r_low;
            // Transfer happens on the coming rising edge
            if (dec_vld === 1'b1 && !r_low) begin
                check_record(idx);
                idx++;
            end
            hold = (dec_vld === 1'b1) && r_low;
            held = dec;
            @(negedge clk);
            cycles++;
        end
        stall   = 1'b0;
        dec_rdy = 1'b1;
        if (idx < rec_count) begin
            $display("Error at %0d ns: output stream stopped early at record %0d of %0d",
                     $time, idx, rec_count);
            errors++;
            aborted = 1'b1;
        end
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %0d records checked, %0d errors",
                 tests_run, name, idx, errors - errs_before);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        clk          = 1'b0;
        rstz         = 1'b0;
        stall        = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        dec_rdy      = 1'b1;
        lfsr         = 32'hadb9;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        prog_len     = 0;
        rec_count    = 0;
        $readmemh("verif/frontend_cases.txt", cases_mem);
        if ($isunknown(cases_mem[0]) || $isunknown(cases_mem[1])) begin
            $display("Error: cases file missing or its header is unreadable");
            errors++;
        end else begin
            prog_len  = int'(cases_mem[0]);
            rec_count = int'(cases_mem[1]);
            if (prog_len == 0 || prog_len > rom_words || rec_count == 0 ||
                hdr_words + prog_len + rec_count * rec_fields > case_words) begin
                $display("Error: cases file header gives %0d words and %0d records",
                         prog_len, rec_count);
                errors++;
            end
        end
        if (errors == 0) begin
            run_stream("sequential fetch, formats and jumps", 1'b0, 1'b0);
            if (!aborted) begin
                run_stream("random memory stalls", 1'b1, 1'b0);
            end
            if (!aborted) begin
                run_stream("random back-pressure", 1'b0, 1'b1);
            end
            if (!aborted) begin
                run_stream("stalls with back-pressure", 1'b1, 1'b1);
            end
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rv_frontend.f ====
design/rv_isa_pkg.sv
design/frontend_pkg.sv
design/instr_fetch.sv
design/instr_rom.sv
design/instr_decode.sv
design/rv_frontend.sv
verif/rv_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: rv_frontend

sources:
  - design/rv_isa_pkg.sv
  - design/frontend_pkg.sv
  - design/instr_fetch.sv
  - design/instr_rom.sv
  - design/instr_decode.sv
  - design/rv_frontend.sv
  - target: test
    files:
      - verif/rv_frontend_tb.sv

// ==== verif/frontend_cases.txt ====
// Header: program word count, expected record count
// Program words from address 0, then records: pc fmt opcode funct3 rd rs1 rs2 imm
// fmt codes: R=0 I=1 S=2 B=3 U=4 J=5 illegal=6
00000010 00000010
// Program
00500093 // 00 addi x1, x0, 5
002081b3 // 04 add x3, x1, x2
0030a423 // 08 sw x3, 8(x1)
fe208ce3 // 0c beq x1, x2, -8
123452b7 // 10 lui x5, 0x12345
fffff317 // 14 auipc x6, 0xfffff
ffc12383 // 18 lw x7, -4(x2)
1234560b // 1c custom-0 opcode, illegal here
010000ef // 20 jal x1, +16
00100493 // 24 wrong path
00200493 // 28 wrong path
00300493 // 2c wrong path
40c58533 // 30 sub x10, x11, x12
fea58fa3 // 34 sb x10, -1(x11)
00008067 // 38 jalr x0, 0(x1)
fc5ff06f // 3c jal x0, -60
// Expected records
00000000 1 13 0 01 00 00 00000005
00000004 0 33 0 03 01 02 00000000
00000008 2 23 2 00 01 03 00000008
0000000c 3 63 0 00 01 02 fffffff8
00000010 4 37 0 05 00 00 12345000
00000014 4 17 0 06 00 00 fffff000
00000018 1 03 2 07 02 00 fffffffc
0000001c 6 0b 0 00 00 00 00000000
00000020 5 6f 0 01 00 00 00000010
00000030 0 33 0 0a 0b 0c 00000000
00000034 2 23 0 00 0b 0a ffffffff
00000038 1 67 0 00 01 00 00000000
0000003c 5 6f 0 00 00 00 ffffffc4
00000000 1 13 0 01 00 00 00000005
00000004 0 33 0 03 01 02 00000000
00000008 2 23 2 00 01 03 00000008
